//--- rtl/fir_pkg.sv
package fir_pkg;

    //****************************************
    // Word widths
    //****************************************
    parameter int SAMPLE_W   = 16;                  // Audio sample width
    parameter int COEFF_W    = 16;                  // Q1.15 coefficient width
    parameter int PROD_W     = SAMPLE_W + COEFF_W;  // Full product width
    parameter int GUARD_W    = 8;                   // Headroom for 256 taps
    parameter int ACC_W      = PROD_W + GUARD_W;    // 40 bit accumulator
    parameter int TAP_ADDR_W = 8;                   // Load address width, max 256 taps

    //****************************************
    // Data types
    //****************************************
    typedef logic signed [SAMPLE_W-1:0] sample_t;   // One audio sample
    typedef logic signed [COEFF_W-1:0]  coeff_t;    // One Q1.15 coefficient
    typedef logic signed [ACC_W-1:0]    acc_t;      // Sum of products
    typedef logic [TAP_ADDR_W-1:0]      tap_addr_t; // Tap index on load port

    // Coefficient load strobe
    typedef struct packed {
        logic      valid;   // Write this cycle
        tap_addr_t addr;    // Target tap
        coeff_t    data;    // New coefficient
    } coeff_wr_t;

    // Per-tap command from controller to MAC
    typedef struct packed {
        logic clear;        // First tap of sweep
        logic enable;       // Tap data valid
        logic last;         // Final tap of sweep
    } mac_cmd_t;

    //****************************************
    // Fixed-point constants
    //****************************************
    parameter int FRAC_BITS = 15;                            // Coefficient fraction bits
    parameter acc_t ROUND_CONST = acc_t'(2 ** (FRAC_BITS - 1)); // Half LSB of output

    // Output clamp limits
    parameter sample_t SAMPLE_MAX = 16'sh7fff;      // +32767
    parameter sample_t SAMPLE_MIN = 16'sh8000;      // -32768

endpackage

//--- rtl/fir_sample_ram.sv
`timescale 1ns/10ps

module fir_sample_ram
#(
    parameter int TAPS = 16                             // History depth
)
(
    input  logic                      clk,              // System clock
    input  logic                      wr_en,            // Write strobe
    input  logic [$clog2(TAPS)-1:0]   wr_ptr,           // Write slot
    input  fir_pkg::sample_t          wr_data,          // Sample or zero
    input  logic [$clog2(TAPS)-1:0]   rd_ptr,           // Read slot
    output fir_pkg::sample_t          rd_data           // Registered read data
);

    import fir_pkg::*;

    localparam int PTR_W = $clog2(TAPS);                // Pointer width

    //****************************************
    // Storage
    //****************************************
    sample_t mem [TAPS];                                // Circular history

    // Pointers wrap at TAPS by width alone
    logic [PTR_W-1:0] wr_slot;                          // Write slot
    logic [PTR_W-1:0] rd_slot;                          // Read slot

    assign wr_slot = wr_ptr;
    assign rd_slot = rd_ptr;

    always_ff @(posedge clk)
    begin
        if (wr_en)
        begin
            mem[wr_slot] <= wr_data;                    // New sample or clear
        end
    end

    //****************************************
    // Registered read
    //****************************************
    always_ff @(posedge clk)
    begin
        rd_data <= mem[rd_slot];                        // One cycle latency
    end

endmodule

//--- rtl/fir_coeff_ram.sv
`timescale 1ns/10ps

module fir_coeff_ram
#(
    parameter int TAPS = 16                             // Number of taps
)
(
    input  logic                      clk,              // System clock
    input  fir_pkg::coeff_wr_t        coeff_wr,         // External load strobe
    input  logic [$clog2(TAPS)-1:0]   rd_idx,           // Tap index
    output fir_pkg::coeff_t           rd_data           // Registered coefficient
);

    import fir_pkg::*;

    localparam int PTR_W = $clog2(TAPS);                // Local index width

    //****************************************
    // Storage
    //****************************************
    coeff_t mem [TAPS];                                 // One word per tap

    logic [PTR_W-1:0] wr_idx;                           // Truncated load address
    logic             wr_en;                            // Load strobe
    coeff_t           wr_word;                          // Load data

    // Upper address bits dropped
    assign wr_idx  = coeff_wr.addr[PTR_W-1:0];
    assign wr_en   = coeff_wr.valid;
    assign wr_word = coeff_wr.data;

    //****************************************
    // Load port
    //****************************************
    always_ff @(posedge clk)
    begin
        if (wr_en)
        begin
            mem[wr_idx] <= wr_word;                     // Takes effect next cycle
        end
    end

    //****************************************
    // Tap read port
    //****************************************
    // Same latency as the history RAM so
    // both operands reach the MAC together
    always_ff @(posedge clk)
    begin
        rd_data <= mem[rd_idx];                         // One cycle latency
    end

endmodule

//--- rtl/fir_mac.sv
`timescale 1ns/10ps

module fir_mac
(
    input  logic               clk,                     // System clock
    input  logic               rstb,                    // Async reset, active low
    input  fir_pkg::mac_cmd_t  cmd,                     // Aligned with RAM data
    input  fir_pkg::sample_t   x_data,                  // History sample
    input  fir_pkg::coeff_t    h_data,                  // Coefficient
    output logic               done,                    // One cycle result strobe
    output fir_pkg::sample_t   result                   // Held until next strobe
);

    import fir_pkg::*;

    //****************************************
    // Product stage
    //****************************************
    logic signed [PROD_W-1:0] prod;                     // Registered product
    logic                     p_valid;                  // Product valid
    logic                     p_clear;                  // Product starts a sum
    logic                     p_last;                   // Product ends a sum

    always_ff @(posedge clk or negedge rstb)
    begin
        if (!rstb)
        begin
            p_valid <= 1'b0;
            p_clear <= 1'b0;
            p_last  <= 1'b0;
        end
        else
        begin
            p_valid <= cmd.enable;
            p_clear <= cmd.enable & cmd.clear;
            p_last  <= cmd.enable & cmd.last;
        end
    end

    always_ff @(posedge clk)
    begin
        if (cmd.enable)
        begin
            prod <= x_data * h_data;                    // Signed 16x16
        end
    end

    //****************************************
    // Accumulator stage
    //****************************************
    acc_t acc;                                          // Running sum
    acc_t prod_ext;                                     // Sign extended product
    logic acc_last;                                     // Sum complete

    assign prod_ext = acc_t'(prod);

    always_ff @(posedge clk or negedge rstb)
    begin
        if (!rstb)
        begin
            acc_last <= 1'b0;
        end
        else
        begin
            acc_last <= p_valid & p_last;
        end
    end

    always_ff @(posedge clk)
    begin
        if (p_valid)
        begin
            acc <= p_clear ? prod_ext : acc + prod_ext; // Load on first tap
        end
    end

    //****************************************
    // Round, shift and clamp
    //****************************************
    acc_t    rounded;                                   // Sum plus half LSB
    acc_t    shifted;                                   // Back to sample scale
    sample_t sat_val;                                   // Clamped output

    always_comb
    begin
        rounded = acc + ROUND_CONST;
        shifted = rounded >>> FRAC_BITS;                // Arithmetic shift
        if (shifted > acc_t'(SAMPLE_MAX))
            sat_val = SAMPLE_MAX;                       // Positive clip
        else if (shifted < acc_t'(SAMPLE_MIN))
            sat_val = SAMPLE_MIN;                       // Negative clip
        else
            sat_val = sample_t'(shifted);
    end

    always_ff @(posedge clk or negedge rstb)
    begin
        if (!rstb)
            done <= 1'b0;
        else
            done <= acc_last;                           // Edge after last add
    end

    always_ff @(posedge clk)
    begin
        if (acc_last)
            result <= sat_val;                          // Held between strobes
    end

endmodule

//--- rtl/fir_ctrl.sv
`timescale 1ns/10ps

module fir_ctrl
#(
    parameter int TAPS = 16                             // Number of taps
)
(
    input  logic                      clk,              // System clock
    input  logic                      rstb,             // Async reset, active low
    input  logic                      in_valid,         // Source has a sample
    output logic                      in_ready,         // Ready to receive
    input  fir_pkg::sample_t          in_data,          // Incoming sample
    output logic                      ram_we,           // History write strobe
    output logic [$clog2(TAPS)-1:0]   wr_ptr,           // History write slot
    output fir_pkg::sample_t          wr_data,          // Sample or zero
    output logic [$clog2(TAPS)-1:0]   rd_ptr,           // History read slot
    output logic [$clog2(TAPS)-1:0]   coeff_idx,        // Coefficient read index
    output fir_pkg::mac_cmd_t         mac_cmd,          // Delayed to match RAM data
    input  logic                      sweep_done        // MAC result strobe
);

    import fir_pkg::*;

    localparam int PTR_W = $clog2(TAPS);                // Pointer width
    localparam logic [PTR_W-1:0] LAST_IDX = PTR_W'(TAPS - 1); // Final slot or tap

    //****************************************
    // One-hot states
    //****************************************
    localparam logic [3:0] CLEAR = 4'b0001,             // Zero the history
                           IDLE  = 4'b0010,             // Wait for a sample
                           SWEEP = 4'b0100,             // Issue tap reads
                           DRAIN = 4'b1000;             // Wait for MAC result

    localparam int CLEAR_ID = 0,
                   IDLE_ID  = 1,
                   SWEEP_ID = 2,
                   DRAIN_ID = 3;

    logic [3:0]       state, state_nxt;                 // Current | next state
    logic [PTR_W-1:0] wr_ptr_nxt;                       // Next write slot
    logic [PTR_W-1:0] rd_ptr_nxt;                       // Next read slot
    logic [PTR_W-1:0] tap_cnt, tap_cnt_nxt;             // Tap counter
    logic             accept;                           // Handshake completes
    logic             clr_flag;                         // Clear sweep active
    mac_cmd_t         cmd_raw;                          // Command with the address

    //****************************************
    // Handshake and write path
    //****************************************
    assign in_ready = state[IDLE_ID];                   // Registered via state
    assign accept   = in_valid & in_ready;
    assign clr_flag = state[CLEAR_ID];
    assign ram_we   = clr_flag | accept;                // Write on accepting edge
    assign wr_data  = clr_flag ? '0 : in_data;          // Zero fill during clear

    assign coeff_idx = tap_cnt;                         // Tap 0 first

    // Command travels with the read address
    always_comb
    begin
        cmd_raw        = '0;
        cmd_raw.enable = state[SWEEP_ID];
        cmd_raw.clear  = state[SWEEP_ID] && (tap_cnt == '0);
        cmd_raw.last   = state[SWEEP_ID] && (tap_cnt == LAST_IDX);
    end

    //****************************************
    // Next state logic
    //****************************************
    always_comb
    begin
        state_nxt   = state;
        wr_ptr_nxt  = wr_ptr;
        rd_ptr_nxt  = rd_ptr;
        tap_cnt_nxt = tap_cnt;

        case (1'b1)
            state[CLEAR_ID]:
            begin
                wr_ptr_nxt = wr_ptr + 1'b1;             // One slot per cycle
                if (wr_ptr == LAST_IDX)
                begin
                    state_nxt = IDLE;                   // Pointer wraps to 0
                end
            end
            state[IDLE_ID]:
            begin
                if (accept)
                begin
                    state_nxt   = SWEEP;
                    wr_ptr_nxt  = wr_ptr + 1'b1;        // Next free slot
                    rd_ptr_nxt  = wr_ptr;               // Newest sample first
                    tap_cnt_nxt = '0;
                end
            end
            state[SWEEP_ID]:
            begin
                rd_ptr_nxt  = rd_ptr - 1'b1;            // Older samples
                tap_cnt_nxt = tap_cnt + 1'b1;           // Higher taps
                if (tap_cnt == LAST_IDX)
                begin
                    state_nxt = DRAIN;
                end
            end
            state[DRAIN_ID]:
            begin
                if (sweep_done)
                begin
                    state_nxt = IDLE;                   // Ready after strobe
                end
            end
            default:
            begin
                state_nxt = CLEAR;                      // Illegal code recovery
            end
        endcase
    end

    //****************************************
    // Registers
    //****************************************
    always_ff @(posedge clk or negedge rstb)
    begin
        if (!rstb)
        begin
            state   <= CLEAR;                           // Sweep starts after reset
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            tap_cnt <= '0;
            mac_cmd <= '0;
        end
        else
        begin
            state   <= state_nxt;
            wr_ptr  <= wr_ptr_nxt;
            rd_ptr  <= rd_ptr_nxt;
            tap_cnt <= tap_cnt_nxt;
            mac_cmd <= cmd_raw;                         // Align with RAM output
        end
    end

endmodule

//--- rtl/fir_filter_top.sv
`timescale 1ns/10ps

module fir_filter_top
#(
    parameter int TAPS = 16                             // Power of two, 2 to 256
)
(
    input  logic                 clk,                   // System clock
    input  logic                 rstb,                  // Async reset, active low
    input  logic                 in_valid,              // Ready to send
    output logic                 in_ready,              // Ready to receive
    input  fir_pkg::sample_t     in_data,               // Input sample
    input  fir_pkg::coeff_wr_t   coeff_wr,              // Coefficient load
    output logic                 out_strobe,            // One cycle per result
    output fir_pkg::sample_t     out_data               // Filtered sample
);

    import fir_pkg::*;

    localparam int PTR_W = $clog2(TAPS);                // Pointer width

    //****************************************
    // Internal wiring
    //****************************************
    logic             ram_we;                           // History write strobe
    logic [PTR_W-1:0] wr_ptr;                           // History write slot
    sample_t          wr_data;                          // Sample or zero
    logic [PTR_W-1:0] rd_ptr;                           // History read slot
    logic [PTR_W-1:0] coeff_idx;                        // Tap index
    mac_cmd_t         mac_cmd;                          // Aligned tap command
    sample_t          x_data;                           // History read data
    coeff_t           h_data;                           // Coefficient read data

    fir_ctrl #(.TAPS(TAPS)) i_fir_ctrl (
        .clk        (clk),
        .rstb       (rstb),
        .in_valid   (in_valid),
        .in_ready   (in_ready),
        .in_data    (in_data),
        .ram_we     (ram_we),
        .wr_ptr     (wr_ptr),
        .wr_data    (wr_data),
        .rd_ptr     (rd_ptr),
        .coeff_idx  (coeff_idx),
        .mac_cmd    (mac_cmd),
        .sweep_done (out_strobe)
    );

    fir_sample_ram #(.TAPS(TAPS)) i_fir_sample_ram (
        .clk     (clk),
        .wr_en   (ram_we),
        .wr_ptr  (wr_ptr),
        .wr_data (wr_data),
        .rd_ptr  (rd_ptr),
        .rd_data (x_data)
    );

    fir_coeff_ram #(.TAPS(TAPS)) i_fir_coeff_ram (
        .clk      (clk),
        .coeff_wr (coeff_wr),
        .rd_idx   (coeff_idx),
        .rd_data  (h_data)
    );

    fir_mac i_fir_mac (
        .clk    (clk),
        .rstb   (rstb),
        .cmd    (mac_cmd),
        .x_data (x_data),
        .h_data (h_data),
        .done   (out_strobe),
        .result (out_data)
    );

endmodule

//--- test/fir_filter_sva.sv
`timescale 1ns/10ps

module fir_filter_sva
#(
    parameter int TAPS = 16                             // Tap count of the bound DUT
)
(
    input logic clk,
    input logic rstb,
    input logic in_valid,
    input logic in_ready,
    input logic out_strobe
);

    // TAPS+3 edges after acceptance, seen one sample later
    localparam int LAT = TAPS + 4;

    logic accept;                                       // Handshake completes
    assign accept = in_valid & in_ready;

    a_strobe_single: assert property (@(posedge clk) disable iff (!rstb)
        out_strobe |=> !out_strobe)
        else $error("out_strobe high two cycles running");

    a_strobe_latency: assert property (@(posedge clk) disable iff (!rstb)
        accept |-> ##LAT out_strobe)
        else $error("out_strobe not TAPS+3 edges after acceptance");

    a_ready_low: assert property (@(posedge clk) disable iff (!rstb)
        accept |=> !in_ready [*LAT])
        else $error("in_ready rose before the output strobe");

endmodule

bind fir_filter_top fir_filter_sva #(.TAPS(TAPS)) i_fir_filter_sva (
    .clk        (clk),
    .rstb       (rstb),
    .in_valid   (in_valid),
    .in_ready   (in_ready),
    .out_strobe (out_strobe)
);

//--- test/tb_fir_filter.sv
`timescale 1ns/10ps

module tb_fir_filter;

    import fir_pkg::*;

    localparam int TAPS      = 16;                      // DUT tap count
    localparam int N_SAMPLES = 115;                     // All tests together
    localparam int LIMIT     = N_SAMPLES * (TAPS + 10) + 3 * TAPS + 200; // Three coefficient loads

    logic      clk = 1'b0;
    logic      rstb;
    logic      in_valid;
    logic      in_ready;
    sample_t   in_data;
    coeff_wr_t coeff_wr;
    logic      out_strobe;
    sample_t   out_data;

    int          cyc          = 0;                      // Negedge count
    int          mismatch_cnt = 0;
    int          fail_cnt     = 0;
    int          out_cnt      = 0;                      // Strobes seen
    int unsigned lcg_state    = 99096;
    sample_t     hist_m [TAPS];                         // Model history with newest at 0
    coeff_t      coef_m [TAPS];                         // Model coefficients
    sample_t     exp_q [$];                             // Pending expected outputs
    int          acc_q [$];                             // Count just after each accepting edge
    sample_t     last_out;                              // Most recent result

    fir_filter_top #(.TAPS(TAPS)) i_fir_filter_top (.*);

    always #5 clk = ~clk;                               // 10 ns period

    function automatic int unsigned lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    // y = sum h[k]*x[n-k] then rounded, shifted and clamped
    function automatic sample_t model_output();
        longint sum = 0;
        for (int k = 0; k < TAPS; k++)
            sum += longint'(coef_m[k]) * longint'(hist_m[k]);
        sum = (sum + (longint'(1) << (FRAC_BITS - 1))) >>> FRAC_BITS;
        if (sum > 32767)
            return 16'sh7fff;
        if (sum < -32768)
            return 16'sh8000;
        return sample_t'(sum);
    endfunction

    task automatic compare_sample(input sample_t got, input sample_t exp, input string what);
        if (got !== exp)
        begin
            mismatch_cnt++;
            $display("MISMATCH at %0t: %s got %0d expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic compare_latency(input int got, input int exp);
        if (got != exp)
        begin
            mismatch_cnt++;
            $display("MISMATCH at %0t: latency got %0d expected %0d", $time, got, exp);
        end
    endtask

    //****************************************
    // Monitor sampled at the falling edge
    //****************************************
    always @(negedge clk)
    begin
        cyc++;
        if (out_strobe)
        begin
            out_cnt++;
            last_out = out_data;
            if (exp_q.size() == 0)
            begin
                fail_cnt++;
                $display("ERROR at %0t: output strobe without an accepted sample", $time);
            end
            else
            begin
                compare_sample(out_data, exp_q.pop_front(), "out_data");
                compare_latency(cyc - acc_q.pop_front(), TAPS + 3);
            end
        end
        else if (acc_q.size() > 0 && cyc - acc_q[0] > TAPS + 3)
        begin
            fail_cnt++;                                 // Strobe never came
            $display("ERROR at %0t: no output strobe for the sample accepted at cycle %0d",
                     $time, acc_q.pop_front());
            void'(exp_q.pop_front());
        end
        if (rstb && in_valid && in_ready)               // Accepted on next rising edge
        begin
            for (int k = TAPS - 1; k > 0; k--)
                hist_m[k] = hist_m[k-1];
            hist_m[0] = in_data;
            exp_q.push_back(model_output());
            acc_q.push_back(cyc + 1);                   // Edges counted from acceptance
        end
    end

    //****************************************
    // Drivers act 1 ns after the rising edge
    //****************************************
    task automatic send_sample(input sample_t value, input int gap, input bit hold);
        repeat (gap)
        begin
            @(posedge clk);
            #1;
        end
        in_valid = 1'b1;
        in_data  = value;
        do
            @(negedge clk);
        while (!in_ready);                              // Wait for handshake
        @(posedge clk);
        #1;
        if (!hold)
            in_valid = 1'b0;
    endtask

    task automatic load_coeffs(input bit full_scale);
        for (int k = 0; k < TAPS; k++)
        begin
            coef_m[k]      = full_scale ? 16'sh7fff : coeff_t'(lcg_next() >> 16);
            coeff_wr.valid = 1'b1;
            coeff_wr.addr  = tap_addr_t'(k);
            coeff_wr.data  = coef_m[k];
            @(posedge clk);
            #1;
        end
        coeff_wr = '0;
    endtask

    task automatic wait_outputs();
        while (exp_q.size() > 0)
            @(negedge clk);
        repeat (2) @(posedge clk);                      // in_ready back high
        #1;
    endtask

    //****************************************
    // Directed tests
    //****************************************
    task automatic impulse_response();
        load_coeffs(1'b0);
        send_sample(16'sh7fff, 0, 1'b0);
        repeat (TAPS - 1) send_sample('0, 0, 1'b0);     // Walks the coefficients out
        wait_outputs();
    endtask

    task automatic random_stream();
        sample_t s;
        int      gap;
        for (int i = 0; i < 40; i++)
        begin
            s   = sample_t'(lcg_next() >> 16);
            gap = int'(lcg_next() % 4);
            send_sample(s, gap, 1'b0);
        end
        wait_outputs();
    endtask

    task automatic clamp_full_scale();
        load_coeffs(1'b1);
        repeat (TAPS) send_sample(16'sh7fff, 0, 1'b0);
        wait_outputs();
        compare_sample(last_out, 16'sh7fff, "positive clamp");
        repeat (TAPS) send_sample(16'sh8000, 0, 1'b0);
        wait_outputs();
        compare_sample(last_out, 16'sh8000, "negative clamp");
    endtask

    task automatic hold_valid_high();
        int start_cnt;
        start_cnt = out_cnt;
        for (int i = 0; i < 10; i++)
            send_sample(sample_t'(1000 * i - 4000), 0, 1'b1); // in_valid never drops
        in_valid = 1'b0;
        wait_outputs();
        if (out_cnt - start_cnt != 10)
        begin
            fail_cnt++;
            $display("ERROR: %0d outputs under back-pressure, 10 samples were sent",
                     out_cnt - start_cnt);
        end
    endtask

    task automatic reload_coeffs();
        load_coeffs(1'b0);                              // History kept
        repeat (8) send_sample(sample_t'(lcg_next() >> 16), 1, 1'b0);
        wait_outputs();
    endtask

    task automatic reset_mid_sweep();
        int low_cnt;
        send_sample(16'sh1234, 0, 1'b0);
        repeat (8) @(posedge clk);                      // Halfway through the sweep
        #1;
        rstb = 1'b0;
        exp_q.delete();
        acc_q.delete();
        foreach (hist_m[k])
            hist_m[k] = '0;
        repeat (4) @(posedge clk);
        #1;
        rstb = 1'b1;
        low_cnt = 0;
        while (!in_ready && low_cnt <= 2 * TAPS)
        begin
            @(negedge clk);
            low_cnt++;
        end
        if (low_cnt != TAPS + 1)
        begin
            fail_cnt++;
            $display("ERROR: in_ready came up %0d cycles after reset, clear sweep takes %0d",
                     low_cnt - 1, TAPS);
        end
        @(posedge clk);
        #1;
        repeat (8) send_sample(sample_t'(lcg_next() >> 16), 0, 1'b0);
        wait_outputs();
    endtask

    task finish_report();
        $display("Summary: %0d outputs seen, %0d value mismatches, %0d other errors",
                 out_cnt, mismatch_cnt, fail_cnt);
        if (mismatch_cnt + fail_cnt == 0)
            $display("All checks passed");
        else
            $display("Checks failed");
        $finish;
    endtask

    initial
    begin
        rstb     = 1'b0;
        in_valid = 1'b0;
        in_data  = '0;
        coeff_wr = '0;
        foreach (hist_m[k])
        begin
            hist_m[k] = '0;
            coef_m[k] = '0;
        end
        repeat (4) @(posedge clk);                      // 4 cycles of reset
        #1;
        rstb = 1'b1;
        while (!in_ready)
            @(negedge clk);                             // Clear sweep done
        @(posedge clk);
        #1;
        impulse_response();
        random_stream();
        clamp_full_scale();
        hold_valid_high();
        reload_coeffs();
        reset_mid_sweep();
        finish_report();
    end

    initial
    begin
        wait (cyc >= LIMIT);
        fail_cnt++;
        $display("ERROR: run did not finish within %0d cycles", LIMIT);
        finish_report();
    end

endmodule

//--- tb.f
rtl/fir_pkg.sv
rtl/fir_sample_ram.sv
rtl/fir_coeff_ram.sv
rtl/fir_mac.sv
rtl/fir_ctrl.sv
rtl/fir_filter_top.sv
test/fir_filter_sva.sv
test/tb_fir_filter.sv
